// File: logic/z80_bus_pkg.sv
/*
  Shared types for the Z80-style external bus unit.
  Widths follow the Z80 pins and are not configurable.
  A fetch carries no write byte, so its data field is free for bit 7 of R.
*/
package z80_bus_pkg;

  // Bus cycle requested by the core
  typedef enum logic [2:0] {
    fetch,
    mem_rd,
    mem_wr,
    io_rd,
    io_wr,
    int_ack
  } cycle_kind_e;

  // One request strobe from the core
  typedef struct packed {
    cycle_kind_e kind;
    logic [15:0] addr;
    // Write byte; bit 7 preloads R7 on a fetch
    logic [7:0]  data;
  } bus_req_t;

  // Response strobe back to the core
  typedef struct packed {
    cycle_kind_e kind;
    // Read byte, zero for writes
    logic [7:0]  data;
  } bus_rsp_t;

  // T-states of one machine cycle
  typedef enum logic [2:0] {
    t_idle,
    t1,
    t2,
    tw,
    t3,
    t4
  } t_state_e;

  // Sequencer view shared by the datapath blocks
  typedef struct packed {
    t_state_e    state;
    cycle_kind_e kind;
    // Final T-state of the cycle
    logic        last;
  } bus_timing_t;

  // Waits inserted by the unit itself, before wait_n is looked at
  function automatic logic [1:0] auto_waits(cycle_kind_e kind);
    case (kind)
      io_rd, io_wr: return 2'd1;
      int_ack:      return 2'd2;
      default:      return 2'd0;
    endcase
  endfunction

endpackage

// File: logic/bus_sequencer.sv
/*
  T-state sequencer of the bus unit.
  req_valid must only be strobed while idle is high; there is no back-pressure.
  wait_n is sampled at the end of T2 or of a TW once the automatic waits are spent.
  Nothing advances while cen is low.
*/
`timescale 1ns/1ns

module bus_sequencer import z80_bus_pkg::*; (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  logic        req_valid,
  input  bus_req_t    req,
  input  logic        wait_n,
  output logic        idle,
  output logic        load,
  output bus_req_t    latched,
  output bus_timing_t timing
);

  t_state_e   state;
  logic [1:0] wait_cnt;
  logic       accept;
  logic       last;
  logic       long_cycle;

  // Request taken on an enabled edge while idle
  assign accept = cen && idle && req_valid;

  // Fetch and int ack run on into T4
  assign long_cycle = (latched.kind == fetch) || (latched.kind == int_ack);
  assign last = (state == t4) || ((state == t3) && !long_cycle);

  assign timing.state = state;
  assign timing.kind  = latched.kind;
  assign timing.last  = last;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= t_idle;
      idle     <= 1'b1;
      load     <= 1'b0;
      wait_cnt <= 2'd0;
      latched  <= '0;
    end else if (cen) begin
      // Load strobe lasts one enabled clock
      load <= accept;
      case (state)
        t_idle: begin
          if (accept) begin
            state    <= t1;
            idle     <= 1'b0;
            latched  <= req;
            wait_cnt <= auto_waits(req.kind);
          end
        end
        t1: state <= t2;
        t2, tw: begin
          if (wait_cnt != 2'd0) begin
            // Automatic wait, wait_n not looked at yet
            state    <= tw;
            wait_cnt <= wait_cnt - 2'd1;
          end else if (!wait_n) begin
            // Target asked for one more TW
            state <= tw;
          end else begin
            state <= t3;
          end
        end
        t3: state <= last ? t_idle : t4;
        t4: state <= t_idle;
        default: state <= t_idle;
      endcase
      // Free again in the clock that carries the response
      if (last) begin
        idle <= 1'b1;
      end
    end
  end

  // Requester error: strobe while a cycle is running
  a_req_only_when_idle: assert property (
    @(posedge clk) disable iff (reset) req_valid |-> idle
  ) else $error("req_valid while bus unit busy");

  // Idle flag and T-state must agree
  a_idle_matches_state: assert property (
    @(posedge clk) disable iff (reset) idle == (state == t_idle)
  ) else $error("idle flag out of step with T-state");

endmodule

// File: logic/bus_strobe_gen.sv
/*
  Registered Z80 control strobes.
  Each pin follows the T-state of the previous enabled clock.
  All strobes default high and are pulled low by kind and T-state.
*/
`timescale 1ns/1ns

module bus_strobe_gen import z80_bus_pkg::*; (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  bus_timing_t timing,
  output logic        m1_n,
  output logic        mreq_n,
  output logic        iorq_n,
  output logic        rd_n,
  output logic        wr_n,
  output logic        rfsh_n
);

  logic m1_cycle;
  logic data_phase;

  // Opcode fetch and int ack are both M1 cycles
  assign m1_cycle = (timing.kind == fetch) || (timing.kind == int_ack);
  // T2 and every TW carry the read or write strobe
  assign data_phase = (timing.state == t2) || (timing.state == tw);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      m1_n   <= 1'b1;
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      rfsh_n <= 1'b1;
    end else if (cen) begin
      m1_n   <= 1'b1;
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      rfsh_n <= 1'b1;
      // M1 held through T1, T2 and any waits
      if (m1_cycle && ((timing.state == t1) || data_phase)) begin
        m1_n <= 1'b0;
      end
      if (data_phase) begin
        case (timing.kind)
          fetch, mem_rd: begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          mem_wr: begin
            mreq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
          io_rd: begin
            iorq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          io_wr: begin
            iorq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
          // Vector read by iorq with m1, no rd
          int_ack: iorq_n <= 1'b0;
          default: ;
        endcase
      end
      // Refresh half of a fetch
      if ((timing.kind == fetch) && ((timing.state == t3) || (timing.state == t4))) begin
        mreq_n <= 1'b0;
        rfsh_n <= 1'b0;
      end
    end
  end

  // Memory and I/O space never selected at once
  a_mreq_iorq_exclusive: assert property (
    @(posedge clk) disable iff (reset) mreq_n || iorq_n
  ) else $error("mreq_n and iorq_n low together");

  a_rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (reset) rd_n || wr_n
  ) else $error("rd_n and wr_n low together");

endmodule

// File: logic/bus_address_path.sv
/*
  Address register, refresh counter and address pin mux.
  The refresh high byte is the request's high byte, standing in for the I register.
  R7 is preloaded from bit 7 of a fetch's data field and never counts.
*/
`timescale 1ns/1ns

module bus_address_path import z80_bus_pkg::*; (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  logic        load,
  input  bus_req_t    latched,
  input  bus_timing_t timing,
  output logic [15:0] addr_bus
);

  logic [15:0] addr_reg;
  logic [15:0] addr_next;
  logic [6:0]  rfsh_cnt;
  logic        r7;
  logic        refresh_phase;

  // T3 and T4 of a fetch put the refresh address out
  assign refresh_phase = (timing.kind == fetch) &&
                         ((timing.state == t3) || (timing.state == t4));

  // Bypass so the new address leaves with the load
  assign addr_next = load ? latched.addr : addr_reg;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr_reg <= 16'h0000;
      addr_bus <= 16'h0000;
      rfsh_cnt <= 7'd0;
      r7       <= 1'b0;
    end else if (cen) begin
      if (load) begin
        addr_reg <= latched.addr;
      end
      if (load && (latched.kind == fetch)) begin
        r7 <= latched.data[7];
      end
      // Low 7 bits step once per fetch, wrap at 128
      if (refresh_phase && (timing.state == t4)) begin
        rfsh_cnt <= rfsh_cnt + 7'd1;
      end
      if (refresh_phase) begin
        addr_bus <= {addr_reg[15:8], r7, rfsh_cnt};
      end else begin
        addr_bus <= addr_next;
      end
    end
  end

endmodule

// File: logic/bus_data_path.sv
/*
  Write data hold, read capture and response strobe.
  dout keeps the request byte until the next request is loaded.
  di is sampled at the end of T3, the clock in which rd_n shows the last data phase.
  rsp_valid is a one-clock strobe; the requester has to take it.
*/
`timescale 1ns/1ns

module bus_data_path import z80_bus_pkg::*; (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  logic [7:0]  di,
  input  logic        load,
  input  bus_req_t    latched,
  input  bus_timing_t timing,
  output logic [7:0]  dout,
  output logic        rsp_valid,
  output bus_rsp_t    rsp
);

  logic [7:0] rd_byte;
  logic [7:0] rd_next;
  logic       is_write;
  logic       capture;

  assign is_write = (timing.kind == mem_wr) || (timing.kind == io_wr);
  // Every other kind reads a byte, vector included
  assign capture = (timing.state == t3) && !is_write;
  // Memory and I/O reads end in T3, so the byte goes straight out
  assign rd_next = capture ? di : rd_byte;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dout      <= 8'h00;
      rsp_valid <= 1'b0;
    end else begin
      // One clock only, even if cen drops after
      rsp_valid <= cen && timing.last;
      if (cen && load) begin
        dout <= latched.data;
      end
    end
  end

  // Read byte and response payload
  always_ff @(posedge clk) begin
    if (cen) begin
      if (capture) begin
        rd_byte <= di;
      end
      if (timing.last) begin
        rsp.kind <= timing.kind;
        rsp.data <= is_write ? 8'h00 : rd_next;
      end
    end
  end

endmodule

// File: logic/z80_bus_unit.sv
/*
  Z80-style external bus unit.
  One request strobe per cycle, accepted only while idle is high.
  Pins are registered and lag the internal T-state by one clock.
  No busrq/busak, halt or tristate handling.
*/
`timescale 1ns/1ns

module z80_bus_unit import z80_bus_pkg::*; (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  logic        req_valid,
  input  bus_req_t    req,
  input  logic [7:0]  di,
  input  logic        wait_n,
  output logic        idle,
  output logic        rsp_valid,
  output bus_rsp_t    rsp,
  output logic [15:0] addr_bus,
  output logic [7:0]  dout,
  output logic        m1_n,
  output logic        mreq_n,
  output logic        iorq_n,
  output logic        rd_n,
  output logic        wr_n,
  output logic        rfsh_n
);

  logic        load;
  bus_req_t    latched;
  bus_timing_t timing;

  // Cycle control
  bus_sequencer u_sequencer (
    .clk       (clk),
    .cen       (cen),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .wait_n    (wait_n),
    .idle      (idle),
    .load      (load),
    .latched   (latched),
    .timing    (timing)
  );

  // Control pins
  bus_strobe_gen u_strobe_gen (
    .clk    (clk),
    .cen    (cen),
    .reset  (reset),
    .timing (timing),
    .m1_n   (m1_n),
    .mreq_n (mreq_n),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .rfsh_n (rfsh_n)
  );

  // Address pins and refresh
  bus_address_path u_address_path (
    .clk      (clk),
    .cen      (cen),
    .reset    (reset),
    .load     (load),
    .latched  (latched),
    .timing   (timing),
    .addr_bus (addr_bus)
  );

  // Data pins and response
  bus_data_path u_data_path (
    .clk       (clk),
    .cen       (cen),
    .reset     (reset),
    .di        (di),
    .load      (load),
    .latched   (latched),
    .timing    (timing),
    .dout      (dout),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

// File: bench/bus_target_model.sv
/*
  Memory and I/O target for the bus unit testbench.
  wait_n is held low up to wait_limit enabled clocks after acceptance,
  so wait_limit covers the automatic waits plus the demanded ones.
  Writes land one clock after wr_n rises. Pin trace is cleared on each acceptance.
*/
`timescale 1ns/1ns

module bus_target_model (
  input  logic        clk,
  input  logic        cen,
  input  logic        reset,
  input  logic        req_valid,
  input  logic        idle,
  input  logic        m1_n,
  input  logic        mreq_n,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        rfsh_n,
  input  logic [15:0] addr_bus,
  input  logic [7:0]  dout,
  input  logic [7:0]  wait_limit,
  output logic [7:0]  di,
  output logic        wait_n
);

  // RST 00h opcode as vector
  localparam logic [7:0] int_vector = 8'hc7;

  logic [7:0]  mem [0:65535];
  logic [7:0]  io [0:255];
  // Pin record per clock with m1, mreq, iorq, rd, wr, rfsh and address
  logic [21:0] trace [$];
  int          wait_cnt;
  logic        wr_was_low;
  logic        saved_iorq;
  logic [15:0] saved_addr;
  logic [7:0]  saved_data;

  initial begin
    // Fill depends on all 16 address bits
    for (int a = 0; a < 65536; a++) begin
      mem[a] = a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
    end
    for (int a = 0; a < 256; a++) begin
      io[a] = a[7:0] ^ 8'ha5;
    end
  end

  // Sequencer only looks at wait_n at its sample points
  assign wait_n = !(wait_cnt <= wait_limit);

  assign di = (!rd_n && !mreq_n) ? mem[addr_bus] :
              (!rd_n && !iorq_n) ? io[addr_bus[7:0]] :
              (!m1_n && !iorq_n) ? int_vector : 8'hff;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      wait_cnt   <= 1000;
      wr_was_low = 1'b0;
      saved_iorq = 1'b1;
      trace.delete();
    end else begin
      if (!m1_n || !mreq_n || !iorq_n) begin
        trace.push_back({m1_n, mreq_n, iorq_n, rd_n, wr_n, rfsh_n, addr_bus});
      end
      // wr_n went high since the last edge
      if (wr_was_low && wr_n) begin
        if (!saved_iorq) begin
          io[saved_addr[7:0]] <= saved_data;
        end else begin
          mem[saved_addr] <= saved_data;
        end
      end
      wr_was_low = !wr_n;
      saved_iorq = iorq_n;
      saved_addr = addr_bus;
      saved_data = dout;
      if (cen) begin
        if (idle && req_valid) begin
          wait_cnt <= 0;
          trace.delete();
        end else if (wait_cnt < 1000) begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

endmodule

// File: bench/z80_bus_tb.sv
/*
  Testbench for the Z80-style bus unit.
  Inputs change on the falling clock edge; responses are compared on the falling edge.
  Latency counts clocks from the one in which the request is presented.
  Refresh bit 7 and the high byte follow the fetch request's data and address.
*/
`timescale 1ns/1ns

module z80_bus_tb import z80_bus_pkg::*; ();

  localparam logic [31:0] seed = 32'h2e4a_5d78;
  localparam logic [7:0]  int_vector = 8'hc7;
  localparam int max_wait = 3;
  localparam int total_requests = 232;
  // Doubled for the random cen test
  localparam int watchdog_ns = total_requests * (6 + max_wait + 2) * 4 * 2 + 500;

  logic        clk;
  logic        cen;
  logic        reset;
  logic        req_valid;
  bus_req_t    req;
  logic [7:0]  di;
  logic        wait_n;
  logic        idle;
  logic        rsp_valid;
  bus_rsp_t    rsp;
  logic [15:0] addr_bus;
  logic [7:0]  dout;
  logic        m1_n;
  logic        mreq_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        rfsh_n;
  logic [7:0]  wait_limit;

  // Reference state
  logic [7:0]  ref_mem [0:65535];
  logic [7:0]  ref_io [0:255];
  logic [6:0]  ref_rfsh;
  logic [31:0] rng;
  logic [31:0] cen_rng;
  bit          cen_random;
  bit          rsp_seen;
  int          cyc = 0;
  int          cen_off = 0;
  int          checks = 0;
  int          errors = 0;

  // Outstanding requests with the oldest at the front
  bus_rsp_t    exp_rsp_q [$];
  int          exp_lat_q [$];
  logic [15:0] exp_rfsh_q [$];
  int          issue_cyc_q [$];
  int          issue_off_q [$];
  logic [15:0] wr_addrs [$];

  z80_bus_unit uut (
    .clk(clk), .cen(cen), .reset(reset), .req_valid(req_valid), .req(req),
    .di(di), .wait_n(wait_n), .idle(idle), .rsp_valid(rsp_valid), .rsp(rsp),
    .addr_bus(addr_bus), .dout(dout), .m1_n(m1_n), .mreq_n(mreq_n),
    .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .rfsh_n(rfsh_n)
  );

  bus_target_model tgt (
    .clk(clk), .cen(cen), .reset(reset), .req_valid(req_valid), .idle(idle),
    .m1_n(m1_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
    .rfsh_n(rfsh_n), .addr_bus(addr_bus), .dout(dout), .wait_limit(wait_limit),
    .di(di), .wait_n(wait_n)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Clock and disabled-clock counters
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!cen) begin
      cen_off <= cen_off + 1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Expected response, latency, refresh address and model wait limit
  function automatic bus_rsp_t reference(input cycle_kind_e kind, input logic [15:0] addr,
                                         input logic [7:0] data, input int n,
                                         output int latency, output logic [15:0] rfsh_addr,
                                         output int limit);
    bus_rsp_t r;
    int       base;
    int       autow;
    r.kind    = kind;
    r.data    = 8'h00;
    rfsh_addr = 16'h0000;
    case (kind)
      fetch: begin
        base      = 4;
        autow     = 0;
        r.data    = ref_mem[addr];
        rfsh_addr = {addr[15:8], data[7], ref_rfsh};
        ref_rfsh  = ref_rfsh + 7'd1;
      end
      mem_rd: begin
        base   = 3;
        autow  = 0;
        r.data = ref_mem[addr];
      end
      mem_wr: begin
        base          = 3;
        autow         = 0;
        ref_mem[addr] = data;
      end
      io_rd: begin
        base   = 4;
        autow  = 1;
        r.data = ref_io[addr[7:0]];
      end
      io_wr: begin
        base              = 4;
        autow             = 1;
        ref_io[addr[7:0]] = data;
      end
      default: begin
        base   = 6;
        autow  = 2;
        r.data = int_vector;
      end
    endcase
    latency = base + n + 1;
    limit   = autow + n;
    return r;
  endfunction

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  // Pin trace of the cycle just answered
  task automatic check_trace(input cycle_kind_e kind, input logic [15:0] rfsh_addr);
    logic [21:0] e;
    bit saw_m1;
    bit saw_mreq;
    bit saw_iorq;
    bit saw_rfsh;
    bit saw_ack;
    saw_m1 = 0;
    saw_mreq = 0;
    saw_iorq = 0;
    saw_rfsh = 0;
    saw_ack = 0;
    for (int i = 0; i < tgt.trace.size(); i++) begin
      e = tgt.trace[i];
      saw_m1   |= !e[21];
      saw_mreq |= !e[20];
      saw_iorq |= !e[19];
      saw_ack  |= !e[21] && !e[19];
      if (!e[16]) begin
        saw_rfsh = 1;
        check_addr("addr_bus refresh", e[15:0], rfsh_addr);
        if (!e[21]) report_error("m1_n low during refresh");
      end
    end
    case (kind)
      fetch: begin
        if (!saw_rfsh) report_error("fetch without a refresh phase");
        if (!saw_m1) report_error("fetch never drove m1_n low");
      end
      io_rd, io_wr: begin
        if (!saw_iorq) report_error("I/O cycle never drove iorq_n low");
        if (saw_mreq) report_error("I/O cycle drove mreq_n low");
      end
      int_ack: begin
        if (!saw_ack) report_error("interrupt acknowledge without m1_n and iorq_n low");
        if (saw_mreq) report_error("interrupt acknowledge drove mreq_n low");
      end
      default: begin
        if (saw_iorq) report_error("memory cycle drove iorq_n low");
        if (!saw_mreq) report_error("memory cycle never drove mreq_n low");
      end
    endcase
  endtask

  // Compare on every response strobe
  always @(negedge clk) begin : compare
    bus_rsp_t    exp;
    int          lat;
    int          issued;
    int          off;
    logic [15:0] rf;
    if (rsp_valid && rsp_seen) begin
      report_error("rsp_valid held high for more than one clock");
    end
    rsp_seen = rsp_valid;
    if (rsp_valid && exp_rsp_q.size() != 0) begin
      // Next request may follow at once
      if (!idle) begin
        report_error("idle did not rise together with rsp_valid");
      end
      exp    = exp_rsp_q.pop_front();
      lat    = exp_lat_q.pop_front();
      rf     = exp_rfsh_q.pop_front();
      issued = issue_cyc_q.pop_front();
      off    = issue_off_q.pop_front();
      check_rsp("rsp", rsp, exp);
      check_latency("latency", cyc - issued, lat + (cen_off - off));
      check_trace(exp.kind, rf);
    end else if (rsp_valid) begin
      report_error("response with no request outstanding");
    end
  end

  // Random clock enable for the stretch test
  always @(negedge clk) begin
    if (cen_random) begin
      cen_rng = xorshift(cen_rng);
      cen = cen_rng[3] | cen_rng[9];
    end
  end

  // Present one request once idle and hold it until an enabled edge
  task automatic issue(input cycle_kind_e kind, input logic [15:0] addr,
                       input logic [7:0] data, input int n);
    bus_rsp_t    exp;
    int          lat;
    int          lim;
    logic [15:0] rf;
    bit          took;
    while (!idle) @(negedge clk);
    exp = reference(kind, addr, data, n, lat, rf, lim);
    exp_rsp_q.push_back(exp);
    exp_lat_q.push_back(lat);
    exp_rfsh_q.push_back(rf);
    issue_cyc_q.push_back(cyc);
    issue_off_q.push_back(cen_off);
    wait_limit = lim[7:0];
    req.kind   = kind;
    req.addr   = addr;
    req.data   = data;
    req_valid  = 1'b1;
    took = 0;
    while (!took) begin
      @(posedge clk);
      took = cen;
      @(negedge clk);
    end
    req_valid = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    while (exp_rsp_q.size() != 0 || !idle) @(negedge clk);
    $display("%-32s done, %0d errors", name, errors - err_before);
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout after %0d ns, the bus unit stopped answering requests", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int          e0;
    logic [31:0] r;
    logic [15:0] a;
    cycle_kind_e k;
    for (int i = 0; i < 65536; i++) begin
      ref_mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h3c;
    end
    for (int i = 0; i < 256; i++) begin
      ref_io[i] = i[7:0] ^ 8'ha5;
    end
    ref_rfsh   = 7'd0;
    rng        = seed;
    cen_rng    = xorshift(seed);
    cen_random = 0;
    rsp_seen   = 0;
    cen        = 1'b1;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    wait_limit = 8'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state followed by write and read back
    e0 = errors;
    check_byte("strobes", {2'b00, m1_n, mreq_n, iorq_n, rd_n, wr_n, rfsh_n}, 8'h3f);
    check_byte("idle,rsp_valid", {6'd0, idle, rsp_valid}, 8'h02);
    check_addr("addr_bus", addr_bus, 16'h0000);
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      issue(mem_wr, r[15:0], r[23:16], 0);
      wr_addrs.push_back(r[15:0]);
    end
    for (int i = 0; i < 8; i++) begin
      issue(mem_rd, wr_addrs[i], 8'h00, 0);
    end
    finish_test("reset and readback", e0);

    // Writes touch only their byte
    e0 = errors;
    wr_addrs.delete();
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      issue(mem_wr, r[15:0], r[31:24], 0);
      wr_addrs.push_back(r[15:0]);
    end
    while (exp_rsp_q.size() != 0 || !idle) @(negedge clk);
    // Model stores one clock after wr_n rises
    repeat (2) @(negedge clk);
    foreach (wr_addrs[i]) begin
      a = wr_addrs[i];
      check_byte("model mem", tgt.mem[a - 16'd1], ref_mem[a - 16'd1]);
      check_byte("model mem", tgt.mem[a], ref_mem[a]);
      check_byte("model mem", tgt.mem[a + 16'd1], ref_mem[a + 16'd1]);
    end
    finish_test("memory write", e0);

    // Refresh counter runs past its wrap
    e0 = errors;
    for (int i = 0; i < 140; i++) begin
      r = next_rand();
      issue(fetch, r[15:0], r[23:16], 0);
    end
    finish_test("fetch and refresh", e0);

    // Every kind with random waits
    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      k = cycle_kind_e'(r[31:29] % 3'd6);
      issue(k, r[15:0], r[23:16], int'(r[25:24]));
    end
    finish_test("random kinds with waits", e0);

    // I/O space and interrupt acknowledge
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      case (r[27:26])
        2'd0: k = io_rd;
        2'd1: k = io_wr;
        default: k = int_ack;
      endcase
      issue(k, r[15:0], r[23:16], int'(r[24]));
    end
    while (exp_rsp_q.size() != 0 || !idle) @(negedge clk);
    repeat (2) @(negedge clk);
    // Port writes land at their port with their byte
    for (int i = 0; i < 256; i++) begin
      check_byte("model io", tgt.io[i], ref_io[i]);
    end
    finish_test("I/O and interrupt acknowledge", e0);

    // Back to back and then with cen toggling
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      issue(cycle_kind_e'(r[31:29] % 3'd6), r[15:0], r[23:16], 0);
    end
    finish_test("back to back", e0);
    e0 = errors;
    cen_random = 1;
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      issue(cycle_kind_e'(r[31:29] % 3'd6), r[15:0], r[23:16], int'(r[24]));
    end
    while (exp_rsp_q.size() != 0 || !idle) @(negedge clk);
    cen_random = 0;
    cen = 1'b1;
    finish_test("clock enable stretch", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/z80_bus_pkg.sv
logic/bus_sequencer.sv
logic/bus_strobe_gen.sv
logic/bus_address_path.sv
logic/bus_data_path.sv
logic/z80_bus_unit.sv
bench/bus_target_model.sv
bench/z80_bus_tb.sv
